/* soc_pkg.sv */
package soc_pkg;

   // bus widths
   localparam int DATA_W = 32;
   localparam int ADDR_W = 32;

   // master request, held stable from valid until ready
   typedef struct packed {
      logic                valid;
      logic [ADDR_W-1:0]   addr;
      logic [DATA_W-1:0]   wdata;
      // nonzero strobe marks a write
      logic [DATA_W/8-1:0] wstrb;
   } bus_req_t;

   // slave response, ready is a one-cycle pulse
   typedef struct packed {
      logic              ready;
      logic [DATA_W-1:0] rdata;
   } bus_rsp_t;

   // peripheral slaves, picked by address bit 30
   typedef enum logic [0:0] {
      SLV_UART = 1'b0,
      SLV_RST  = 1'b1
   } slave_e;

endpackage

/* mem_select.sv */
`timescale 1ns/1ps

module mem_select (
   input  soc_pkg::bus_req_t req,
   output soc_pkg::bus_rsp_t rsp,
   output soc_pkg::bus_req_t mem_req,
   input  soc_pkg::bus_rsp_t mem_rsp,
   output soc_pkg::bus_req_t per_req,
   input  soc_pkg::bus_rsp_t per_rsp
);

   import soc_pkg::*;

   logic per_sel;

   // top address bit splits memory from peripherals
   assign per_sel = req.addr[ADDR_W-1];

   always_comb begin
      // payload goes to both sides, valid only to the chosen one
      mem_req       = req;
      per_req       = req;
      mem_req.valid = req.valid & ~per_sel;
      per_req.valid = req.valid & per_sel;

      if (per_sel) begin
         rsp = per_rsp;
      end else begin
         rsp = mem_rsp;
      end
   end

endmodule

/* int_mem.sv */
`timescale 1ns/1ps

module int_mem #(
   parameter int MEM_ADDR_W  = 12,
   parameter int BOOT_ADDR_W = 10
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              boot,
   input  soc_pkg::bus_req_t req,
   output soc_pkg::bus_rsp_t rsp
);

   import soc_pkg::*;

   localparam int IDX_W   = MEM_ADDR_W - 2;
   localparam int N_WORDS = 2 ** IDX_W;

   logic [DATA_W-1:0] mem [N_WORDS];

   logic              clearing;
   logic [IDX_W-1:0]  clr_idx;
   logic [IDX_W-1:0]  idx;
   logic              accept;
   logic              in_boot;
   logic              wr_en;
   logic              ready_q;
   logic [DATA_W-1:0] rdata_q;

   assign idx     = req.addr[MEM_ADDR_W-1:2];
   // one answer per valid, none until the clear is over
   assign accept  = req.valid & ~ready_q & ~clearing;
   // boot region is the low end of the word space
   assign in_boot = (req.addr[MEM_ADDR_W-1:BOOT_ADDR_W] == '0);
   // protected writes still get their ready
   assign wr_en   = rst_n & accept & (|req.wstrb) & ~(boot & in_boot);

   // clear walks every word once after reset
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         clearing <= 1'b1;
         clr_idx  <= '0;
      end else if (clearing) begin
         clr_idx <= clr_idx + 1'b1;
         if (&clr_idx) begin
            clearing <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (clearing) begin
         mem[clr_idx] <= '0;
      end else if (wr_en) begin
         for (int b = 0; b < DATA_W / 8; b++) begin
            if (req.wstrb[b]) begin
               mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         rdata_q <= mem[idx];
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ready_q <= 1'b0;
      end else begin
         ready_q <= accept;
      end
   end

   assign rsp = '{ready: ready_q, rdata: rdata_q};

endmodule

/* periph_interconnect.sv */
`timescale 1ns/1ps

module periph_interconnect (
   input  soc_pkg::bus_req_t req,
   output soc_pkg::bus_rsp_t rsp,
   output logic              uart_valid,
   input  soc_pkg::bus_rsp_t uart_rsp,
   output logic              rst_valid,
   input  soc_pkg::bus_rsp_t rst_rsp
);

   import soc_pkg::*;

   slave_e sel;

   // bit below the peripheral flag picks the slave
   assign sel = slave_e'(req.addr[ADDR_W-2]);

   always_comb begin
      uart_valid = 1'b0;
      rst_valid  = 1'b0;
      rsp        = uart_rsp;

      case (sel)
         SLV_UART: begin
            uart_valid = req.valid;
            rsp        = uart_rsp;
         end
         SLV_RST: begin
            rst_valid = req.valid;
            rsp       = rst_rsp;
         end
         default: begin
            rsp = uart_rsp;
         end
      endcase
   end

endmodule

/* uart_ctrl.sv */
`timescale 1ns/1ps

module uart_ctrl #(
   parameter int UART_DIV = 4
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              valid,
   input  soc_pkg::bus_req_t req,
   output soc_pkg::bus_rsp_t rsp,
   output logic              txd,
   input  logic              rxd,
   output logic              rts,
   input  logic              cts
);

   import soc_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_START,
      ST_DATA,
      ST_STOP
   } uart_state_e;

   localparam logic [2:0] REG_TXDATA = 3'd0;
   localparam logic [2:0] REG_STATUS = 3'd1;
   localparam logic [2:0] REG_RXDATA = 3'd2;
   localparam int CNT_W = (UART_DIV > 1) ? $clog2(UART_DIV) : 1;
   // start bit sample point, two sync stages already behind
   localparam int MID = (UART_DIV > 1) ? UART_DIV / 2 - 1 : 0;

   logic              ready_q;
   logic [DATA_W-1:0] rdata_q;
   logic              accept;
   logic              wr;
   logic              rd;
   logic [2:0]        reg_sel;

   uart_state_e       tx_state;
   logic [CNT_W-1:0]  tx_cnt;
   logic [2:0]        tx_bit;
   logic [7:0]        tx_shift;
   logic              tx_pend;
   logic              tx_busy;
   logic              tx_load;
   logic              tx_tick;

   uart_state_e       rx_state;
   logic [CNT_W-1:0]  rx_cnt;
   logic [2:0]        rx_bit;
   logic [7:0]        rx_shift;
   logic [7:0]        rx_data;
   logic              rx_valid;
   logic              rx_meta;
   logic              rx_sync;
   logic              rx_tick;
   logic              rx_done;

   assign reg_sel = req.addr[4:2];
   assign accept  = valid & ~ready_q;
   assign wr      = accept & (|req.wstrb);
   assign rd      = accept & ~(|req.wstrb);
   // busy covers a byte still waiting for cts
   assign tx_busy = tx_pend | (tx_state != ST_IDLE);
   assign tx_load = wr & (reg_sel == REG_TXDATA) & ~tx_busy;
   assign tx_tick = (tx_cnt == CNT_W'(UART_DIV - 1));
   assign rx_tick = (rx_cnt == CNT_W'(UART_DIV - 1));
   assign rx_done = (rx_state == ST_STOP) & rx_tick & rx_sync;
   assign rts     = ~rx_valid;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ready_q <= 1'b0;
      end else begin
         ready_q <= accept;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         case (reg_sel)
            REG_STATUS: rdata_q <= {{(DATA_W-2){1'b0}}, rx_valid, tx_busy};
            REG_RXDATA: rdata_q <= {{(DATA_W-8){1'b0}}, rx_data};
            default:    rdata_q <= '0;
         endcase
      end
   end

   assign rsp = '{ready: ready_q, rdata: rdata_q};

   // transmit engine
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tx_state <= ST_IDLE;
         tx_pend  <= 1'b0;
         tx_cnt   <= '0;
         tx_bit   <= '0;
      end else begin
         if (tx_load) begin
            tx_pend <= 1'b1;
         end
         tx_cnt <= (tx_state == ST_IDLE || tx_tick) ? '0 : tx_cnt + 1'b1;
         case (tx_state)
            ST_IDLE: begin
               // far end must be ready before a frame begins
               if (tx_pend && cts) begin
                  tx_pend  <= 1'b0;
                  tx_state <= ST_START;
               end
            end
            ST_START: begin
               if (tx_tick) begin
                  tx_bit   <= '0;
                  tx_state <= ST_DATA;
               end
            end
            ST_DATA: begin
               if (tx_tick) begin
                  tx_bit <= tx_bit + 1'b1;
                  if (tx_bit == 3'd7) begin
                     tx_state <= ST_STOP;
                  end
               end
            end
            ST_STOP: begin
               if (tx_tick) begin
                  tx_state <= ST_IDLE;
               end
            end
         endcase
      end
   end

   // lsb goes out first
   always_ff @(posedge clk) begin
      if (tx_load) begin
         tx_shift <= req.wdata[7:0];
      end else if (tx_state == ST_DATA && tx_tick) begin
         tx_shift <= {1'b0, tx_shift[7:1]};
      end
   end

   always_comb begin
      case (tx_state)
         ST_START: txd = 1'b0;
         ST_DATA:  txd = tx_shift[0];
         default:  txd = 1'b1;
      endcase
   end

   // rxd sync, idles high
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= rxd;
         rx_sync <= rx_meta;
      end
   end

   // receive engine
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rx_state <= ST_IDLE;
         rx_cnt   <= '0;
         rx_bit   <= '0;
         rx_valid <= 1'b0;
      end else begin
         rx_cnt <= (rx_state == ST_IDLE || rx_tick) ? '0 : rx_cnt + 1'b1;
         if (rd && reg_sel == REG_RXDATA) begin
            rx_valid <= 1'b0;
         end
         case (rx_state)
            ST_IDLE: begin
               if (!rx_sync) begin
                  rx_state <= ST_START;
               end
            end
            ST_START: begin
               if (rx_cnt == CNT_W'(MID)) begin
                  rx_cnt <= '0;
                  rx_bit <= '0;
                  // line back high at mid start bit is a glitch
                  rx_state <= rx_sync ? ST_IDLE : ST_DATA;
               end
            end
            ST_DATA: begin
               if (rx_tick) begin
                  rx_bit <= rx_bit + 1'b1;
                  if (rx_bit == 3'd7) begin
                     rx_state <= ST_STOP;
                  end
               end
            end
            ST_STOP: begin
               if (rx_tick) begin
                  rx_state <= ST_IDLE;
               end
               if (rx_done) begin
                  rx_valid <= 1'b1;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rx_state == ST_DATA && rx_tick) begin
         rx_shift <= {rx_sync, rx_shift[7:1]};
      end
      if (rx_done) begin
         rx_data <= rx_shift;
      end
   end

endmodule

/* rst_ctr.sv */
`timescale 1ns/1ps

module rst_ctr #(
   parameter int SOFT_RST_CYCLES = 16
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              valid,
   input  soc_pkg::bus_req_t req,
   output soc_pkg::bus_rsp_t rsp,
   output logic              sys_rst_n,
   output logic              boot
);

   import soc_pkg::*;

   localparam int CNT_W = $clog2(SOFT_RST_CYCLES + 1);

   logic              ready_q;
   logic [DATA_W-1:0] rdata_q;
   logic              accept;
   logic              soft_req;
   logic [CNT_W-1:0]  rst_cnt;

   assign accept   = valid & ~ready_q;
   // write of bit 0 asks for a soft reset
   assign soft_req = accept & (|req.wstrb) & req.wdata[0];

   // runs on the hard reset only, so it keeps counting
   // while the rest of the core is held
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ready_q   <= 1'b0;
         boot      <= 1'b1;
         rst_cnt   <= '0;
         sys_rst_n <= 1'b0;
      end else begin
         ready_q <= accept;
         // low one cycle after the ack, for the full count
         sys_rst_n <= (rst_cnt == '0);
         if (soft_req) begin
            boot    <= 1'b0;
            rst_cnt <= CNT_W'(SOFT_RST_CYCLES);
         end else if (rst_cnt != '0) begin
            rst_cnt <= rst_cnt - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         rdata_q <= {{(DATA_W-1){1'b0}}, boot};
      end
   end

   assign rsp = '{ready: ready_q, rdata: rdata_q};

endmodule

/* soc_system.sv */
`timescale 1ns/1ps

module soc_system #(
   parameter int MEM_ADDR_W      = 12,
   parameter int BOOT_ADDR_W     = 10,
   parameter int UART_DIV        = 4,
   parameter int SOFT_RST_CYCLES = 16
) (
   input  logic              clk,
   input  logic              rst_n,
   input  soc_pkg::bus_req_t req,
   output soc_pkg::bus_rsp_t rsp,
   output logic              uart_txd,
   input  logic              uart_rxd,
   output logic              uart_rts,
   input  logic              uart_cts
);

   import soc_pkg::*;

   localparam int N_SLV = 2 ** $bits(slave_e);

   // core reset, hard or soft
   logic     sys_rst_n;
   logic     boot;

   bus_req_t mem_req;
   bus_rsp_t mem_rsp;
   bus_req_t per_req;
   bus_rsp_t per_rsp;

   // per slave valid and response, indexed by slave
   logic [N_SLV-1:0] slv_valid;
   bus_rsp_t         slv_rsp [N_SLV];

   mem_select mem_select0 (
      .req     (req),
      .rsp     (rsp),
      .mem_req (mem_req),
      .mem_rsp (mem_rsp),
      .per_req (per_req),
      .per_rsp (per_rsp)
   );

   int_mem #(
      .MEM_ADDR_W  (MEM_ADDR_W),
      .BOOT_ADDR_W (BOOT_ADDR_W)
   ) int_mem0 (
      .clk   (clk),
      .rst_n (sys_rst_n),
      .boot  (boot),
      .req   (mem_req),
      .rsp   (mem_rsp)
   );

   periph_interconnect intercon0 (
      .req        (per_req),
      .rsp        (per_rsp),
      .uart_valid (slv_valid[SLV_UART]),
      .uart_rsp   (slv_rsp[SLV_UART]),
      .rst_valid  (slv_valid[SLV_RST]),
      .rst_rsp    (slv_rsp[SLV_RST])
   );

   uart_ctrl #(
      .UART_DIV (UART_DIV)
   ) uart0 (
      .clk   (clk),
      .rst_n (sys_rst_n),
      .valid (slv_valid[SLV_UART]),
      .req   (per_req),
      .rsp   (slv_rsp[SLV_UART]),
      .txd   (uart_txd),
      .rxd   (uart_rxd),
      .rts   (uart_rts),
      .cts   (uart_cts)
   );

   rst_ctr #(
      .SOFT_RST_CYCLES (SOFT_RST_CYCLES)
   ) rst_ctr0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .valid     (slv_valid[SLV_RST]),
      .req       (per_req),
      .rsp       (slv_rsp[SLV_RST]),
      .sys_rst_n (sys_rst_n),
      .boot      (boot)
   );

endmodule

/* tb_soc_system.sv */
`timescale 1ns/1ps

module tb_soc_system;

   import soc_pkg::*;

   localparam int MEM_ADDR_W      = 12;
   localparam int BOOT_ADDR_W     = 10;
   localparam int UART_DIV        = 4;
   localparam int SOFT_RST_CYCLES = 16;

   localparam int CLEAR_CYCLES = 2 ** (MEM_ADDR_W - 2);
   // upper half of the memory for the random phase
   localparam int UPPER_BASE   = 2 ** (MEM_ADDR_W - 1);
   localparam int UPPER_WORDS  = 2 ** (MEM_ADDR_W - 3);
   localparam int BUS_TIMEOUT  = 5000;
   localparam int POLL_TIMEOUT = 2000;
   localparam int N_RANDOM     = 32;

   logic        clk;
   logic        rst_n;
   bus_req_t    req;
   bus_rsp_t    rsp;
   logic        uart_txd;
   logic        uart_rxd;
   logic        uart_rts;
   logic        uart_cts;

   int unsigned cycle_cnt = 0;
   logic [31:0] model [UPPER_WORDS];

   // uart loopback of data and flow control
   assign uart_rxd = uart_txd;
   assign uart_cts = uart_rts;

   soc_system #(
      .MEM_ADDR_W      (MEM_ADDR_W),
      .BOOT_ADDR_W     (BOOT_ADDR_W),
      .UART_DIV        (UART_DIV),
      .SOFT_RST_CYCLES (SOFT_RST_CYCLES)
   ) u_dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .req      (req),
      .rsp      (rsp),
      .uart_txd (uart_txd),
      .uart_rxd (uart_rxd),
      .uart_rts (uart_rts),
      .uart_cts (uart_cts)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   task automatic stop_with_failure();
      $display("TESTS FAILED");
      $fatal(1, "simulation stopped at the first failure");
   endtask

   task automatic compare_value(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
      if (actual !== expected) begin
         $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
         stop_with_failure();
      end
   endtask

   // one request held until ready and dropped at the edge that samples it
   task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] wstrb, output logic [31:0] rdata,
                             output int waited);
      bus_req_t r;
      logic     got;
      r.valid = 1'b1;
      r.addr  = addr;
      r.wdata = wdata;
      r.wstrb = wstrb;
      got     = 1'b0;
      waited  = 0;
      @(posedge clk);
      req <= r;
      while (!got && waited < BUS_TIMEOUT) begin
         @(negedge clk);
         if (rsp.ready) begin
            got = 1'b1;
         end else begin
            waited++;
         end
      end
      if (!got) begin
         $display("bus access timed out at %0t ns, addr %h", $time, addr);
         stop_with_failure();
      end else begin
         rdata = rsp.rdata;
         @(posedge clk);
         req <= '0;
      end
   endtask

   task automatic poll_until(input logic [31:0] addr, input logic [31:0] mask,
                             input logic [31:0] expected);
      logic [31:0] data;
      int          waited;
      int unsigned start;
      logic        done;
      start = cycle_cnt;
      done  = 1'b0;
      while (!done) begin
         bus_access(addr, 32'h0, 4'h0, data, waited);
         if ((data & mask) == expected) begin
            done = 1'b1;
         end else if (cycle_cnt - start > POLL_TIMEOUT) begin
            $display("poll of %h never reached %h under mask %h", addr, expected, mask);
            stop_with_failure();
         end
      end
   endtask

   function automatic logic [31:0] next_random(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic run_file();
      int          fd;
      int          n;
      int          line_no;
      int          waited;
      string       line;
      logic [7:0]  op;
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [3:0]  wstrb;
      logic [31:0] mask;
      logic [31:0] expected;
      logic [31:0] data;
      line_no = 0;
      fd = $fopen("soc_tests.txt", "r");
      if (fd == 0) begin
         $display("could not open soc_tests.txt");
         stop_with_failure();
      end else begin
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            line_no++;
            // blank and comment lines hold no operation
            if (n > 1 && line.getc(0) != "#") begin
               n = $sscanf(line, "%c %h %h %h %h %h", op, addr, wdata, wstrb, mask,
                           expected);
               if (n != 6) begin
                  $display("line %0d of soc_tests.txt has %0d fields, not 6", line_no, n);
                  stop_with_failure();
               end else begin
                  case (op)
                     "w": bus_access(addr, wdata, wstrb, data, waited);
                     "r": begin
                        bus_access(addr, 32'h0, 4'h0, data, waited);
                        compare_value($sformatf("rdata on line %0d", line_no), data & mask,
                                      expected);
                     end
                     "p": poll_until(addr, mask, expected);
                     // wdata column holds the cycle count
                     "s": repeat (wdata) @(posedge clk);
                     default: begin
                        $display("line %0d of soc_tests.txt has unknown operation %c",
                                 line_no, op);
                        stop_with_failure();
                     end
                  endcase
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // upper half was cleared by the soft reset and not written since
   task automatic random_phase();
      logic [31:0] seed;
      logic [31:0] wdata;
      logic [31:0] data;
      logic [3:0]  strb;
      int          idx [N_RANDOM];
      int          waited;
      seed = 32'h29a3a345;
      for (int i = 0; i < UPPER_WORDS; i++) begin
         model[i] = '0;
      end
      for (int n = 0; n < N_RANDOM; n++) begin
         seed   = next_random(seed);
         idx[n] = int'(seed % UPPER_WORDS);
         seed   = next_random(seed);
         wdata  = seed;
         seed   = next_random(seed);
         strb   = seed[3:0];
         // zero strobe would make it a read
         if (strb == 4'h0) begin
            strb = 4'hf;
         end
         for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
               model[idx[n]][8*b +: 8] = wdata[8*b +: 8];
            end
         end
         bus_access(32'(UPPER_BASE + idx[n] * 4), wdata, strb, data, waited);
      end
      for (int n = 0; n < N_RANDOM; n++) begin
         bus_access(32'(UPPER_BASE + idx[n] * 4), 32'h0, 4'h0, data, waited);
         compare_value($sformatf("mem word %0d", idx[n] + UPPER_WORDS), data, model[idx[n]]);
      end
   endtask

   initial begin
      logic [31:0] data;
      int          waited;
      rst_n <= 1'b0;
      req   <= '0;
      repeat (3) @(posedge clk);
      // idle levels of the outputs while reset is held
      @(negedge clk);
      compare_value("uart_txd in reset", {31'h0, uart_txd}, 32'h1);
      compare_value("uart_rts in reset", {31'h0, uart_rts}, 32'h1);
      compare_value("rsp.ready in reset", {31'h0, rsp.ready}, 32'h0);
      @(posedge clk);
      rst_n <= 1'b1;
      // first access lands in the clear and must wait it out
      bus_access(32'(UPPER_BASE), 32'h0, 4'h0, data, waited);
      if (waited < CLEAR_CYCLES) begin
         $display("first memory read answered after %0d cycles, before the clear ended",
                  waited);
         stop_with_failure();
      end
      compare_value("rdata after clear", data, 32'h0);
      run_file();
      random_phase();
      $display("TESTS PASSED");
      $finish;
   end

endmodule

/* soc_tests.txt */
# op addr wdata wstrb mask expected, every field after the op letter in hex
# w write, r read and compare under mask, p poll until match, s wait wdata cycles
# byte strobes in the upper memory half
w 00000800 11223344 f 00000000 00000000
r 00000800 00000000 0 ffffffff 11223344
w 00000800 aabbccdd 2 00000000 00000000
r 00000800 00000000 0 ffffffff 1122cc44
w 00000804 deadbeef 5 00000000 00000000
r 00000804 00000000 0 ffffffff 00ad00ef
w 00000808 cafef00d c 00000000 00000000
r 00000808 00000000 0 ffffffff cafe0000
# boot region is write protected while boot is set
r c0000000 00000000 0 00000001 00000001
w 00000010 12345678 f 00000000 00000000
r 00000010 00000000 0 ffffffff 00000000
w 000003fc ffffffff f 00000000 00000000
r 000003fc 00000000 0 ffffffff 00000000
w 00000400 0badf00d f 00000000 00000000
r 00000400 00000000 0 ffffffff 0badf00d
# uart loopback
w 80000000 0000005a 1 00000000 00000000
p 80000004 00000000 0 00000002 00000002
r 80000008 00000000 0 000000ff 0000005a
r 80000004 00000000 0 00000002 00000000
# flow control, second byte held while the first is unread
w 80000000 000000a5 1 00000000 00000000
p 80000004 00000000 0 00000003 00000002
w 80000000 0000003c 1 00000000 00000000
s 00000000 00000040 0 00000000 00000000
r 80000004 00000000 0 00000003 00000003
r 80000008 00000000 0 000000ff 000000a5
p 80000004 00000000 0 00000003 00000002
r 80000008 00000000 0 000000ff 0000003c
r 80000004 00000000 0 00000003 00000000
# soft reset clears boot and memory
w c0000000 00000001 f 00000000 00000000
r c0000000 00000000 0 00000001 00000000
r 00000800 00000000 0 ffffffff 00000000
r 00000400 00000000 0 ffffffff 00000000
w 00000010 12345678 f 00000000 00000000
r 00000010 00000000 0 ffffffff 12345678

/* build.f */
soc_pkg.sv
mem_select.sv
int_mem.sv
periph_interconnect.sv
uart_ctrl.sv
rst_ctr.sv
soc_system.sv
tb_soc_system.sv

/* Makefile */
TOP = tb_soc_system

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f build.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
